//--- Makefile
# Verilator build, run and lint for the MAC address table

VERILATOR ?= verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
TOP = tb_mac_table
RTL_TOP = mac_table
FLIST = mac_table.f
OBJ_DIR = obj_dir
PASS_MSG = TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/learn_queue.sv
`timescale 1ns/1ps
`default_nettype none

module learn_queue import mac_table_pkg::*; (
	input wire clk,
	input wire reset,

	// Source read request from decode
	input wire src_en,
	input wire row_t src_row,

	// Context and source check result
	input wire ctx_valid,
	input wire mac_t ctx_src_mac,
	input wire vlan_t ctx_vlan,
	input wire port_t ctx_src_port,
	input wire src_known,

	// Learn port of the table
	output logic ln_en,
	output row_t ln_row,
	output logic [ASSOC_WAYS-1:0] ln_we,
	output mac_t ln_wmac,
	output vlan_t ln_wvlan,
	output port_t ln_wport
);

	// Registered learn decision
	logic learn_req;
	mac_t learn_mac;
	vlan_t learn_vlan;
	port_t learn_port;
	way_t learn_way;

	// Replacement way, steps once per decision
	way_t way_ctr;

	// Pending set
	logic [PENDING_SIZE-1:0] pend_valid;
	mac_t pend_mac [PENDING_SIZE];
	vlan_t pend_vlan [PENDING_SIZE];
	port_t pend_port [PENDING_SIZE];
	way_t pend_way [PENDING_SIZE];

	logic learn_now;
	logic already_pending;
	logic free_found;
	logic [PEND_BITS-1:0] free_slot;
	logic wr_found;
	logic [PEND_BITS-1:0] wr_slot;
	logic wr_go;

	////////////////////////////////////////////////////////////
	// Learn decision

	// Unknown unicast sources only
	assign learn_now = ctx_valid && !src_known && !ctx_src_mac[GROUP_BIT];

	always_ff @(posedge clk) begin
		if (reset) begin
			learn_req <= 1'b0;
			way_ctr <= '0;
		end else begin
			learn_req <= learn_now;
			if (learn_now)
				way_ctr <= way_ctr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (learn_now) begin
			learn_mac <= ctx_src_mac;
			learn_vlan <= ctx_vlan;
			learn_port <= ctx_src_port;
			learn_way <= way_ctr;
		end
	end

	////////////////////////////////////////////////////////////
	// Pending set search

	// Downward scans, so the lowest slot is picked
	always_comb begin
		already_pending = 1'b0;
		free_found = 1'b0;
		free_slot = '0;
		wr_found = 1'b0;
		wr_slot = '0;
		for (int i = PENDING_SIZE - 1; i >= 0; i--) begin
			if (pend_valid[i] && (pend_mac[i] == learn_mac) &&
				(pend_vlan[i] == learn_vlan) && (pend_port[i] == learn_port))
				already_pending = 1'b1;
			if (!pend_valid[i]) begin
				free_found = 1'b1;
				free_slot = PEND_BITS'(i);
			end else begin
				wr_found = 1'b1;
				wr_slot = PEND_BITS'(i);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Learn port arbitration

	// Source reads first, then one pending write
	assign wr_go = wr_found && !src_en;

	always_comb begin
		ln_en = src_en || wr_found;
		ln_row = src_en ? src_row : table_hash(pend_mac[wr_slot], pend_vlan[wr_slot]);
		ln_we = '0;
		if (wr_go)
			ln_we[pend_way[wr_slot]] = 1'b1;
		ln_wmac = pend_mac[wr_slot];
		ln_wvlan = pend_vlan[wr_slot];
		ln_wport = pend_port[wr_slot];
	end

	// Slot insert and clear never hit the same slot
	always_ff @(posedge clk) begin
		if (reset) begin
			pend_valid <= '0;
		end else begin
			if (wr_go)
				pend_valid[wr_slot] <= 1'b0;
			// Full set drops the address
			if (learn_req && !already_pending && free_found)
				pend_valid[free_slot] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (learn_req && !already_pending && free_found) begin
			pend_mac[free_slot] <= learn_mac;
			pend_vlan[free_slot] <= learn_vlan;
			pend_port[free_slot] <= learn_port;
			pend_way[free_slot] <= learn_way;
		end
	end

endmodule

`default_nettype wire

//--- logic/mac_table.sv
`timescale 1ns/1ps
`default_nettype none

module mac_table import mac_table_pkg::*; (
	input wire clk,
	input wire reset,

	input wire req_valid,
	input wire port_t req_src_port,
	input wire vlan_t req_vlan,
	input wire mac_t req_src_mac,
	input wire mac_t req_dst_mac,

	output logic lookup_done,
	output logic lookup_hit,
	output port_t lookup_dst_port
);

	// Decode outputs
	logic lk_en;
	row_t lk_row;
	logic src_en;
	row_t src_row;
	logic ctx_valid;
	vlan_t ctx_vlan;
	mac_t ctx_src_mac;
	port_t ctx_src_port;
	mac_t ctx_dst_mac;

	// Learn port
	logic ln_en;
	row_t ln_row;
	logic [ASSOC_WAYS-1:0] ln_we;
	mac_t ln_wmac;
	vlan_t ln_wvlan;
	port_t ln_wport;

	// Read data, per way
	logic [ASSOC_WAYS-1:0] lk_rdata_valid;
	mac_t [ASSOC_WAYS-1:0] lk_rdata_mac;
	vlan_t [ASSOC_WAYS-1:0] lk_rdata_vlan;
	port_t [ASSOC_WAYS-1:0] lk_rdata_port;
	logic [ASSOC_WAYS-1:0] ln_rdata_valid;
	mac_t [ASSOC_WAYS-1:0] ln_rdata_mac;
	vlan_t [ASSOC_WAYS-1:0] ln_rdata_vlan;
	port_t [ASSOC_WAYS-1:0] ln_rdata_port;

	logic src_known;

	request_decode i_request_decode (
		.clk(clk), .reset(reset), .req_valid(req_valid),
		.req_src_port(req_src_port), .req_vlan(req_vlan),
		.req_src_mac(req_src_mac), .req_dst_mac(req_dst_mac),
		.lk_en(lk_en), .lk_row(lk_row), .src_en(src_en), .src_row(src_row),
		.ctx_valid(ctx_valid), .ctx_vlan(ctx_vlan), .ctx_src_mac(ctx_src_mac),
		.ctx_src_port(ctx_src_port), .ctx_dst_mac(ctx_dst_mac)
	);

	table_memory i_table_memory (
		.clk(clk), .reset(reset), .lk_en(lk_en), .lk_row(lk_row),
		.lk_rdata_valid(lk_rdata_valid), .lk_rdata_mac(lk_rdata_mac),
		.lk_rdata_vlan(lk_rdata_vlan), .lk_rdata_port(lk_rdata_port),
		.ln_en(ln_en), .ln_row(ln_row), .ln_we(ln_we),
		.ln_wmac(ln_wmac), .ln_wvlan(ln_wvlan), .ln_wport(ln_wport),
		.ln_rdata_valid(ln_rdata_valid), .ln_rdata_mac(ln_rdata_mac),
		.ln_rdata_vlan(ln_rdata_vlan), .ln_rdata_port(ln_rdata_port)
	);

	// Destination lookup, registered result drives the outputs
	way_match i_dst_match (
		.clk(clk), .reset(reset), .res_en(ctx_valid),
		.key_mac(ctx_dst_mac), .key_vlan(ctx_vlan),
		.way_valid(lk_rdata_valid), .way_mac(lk_rdata_mac),
		.way_vlan(lk_rdata_vlan), .way_port(lk_rdata_port),
		.hit(), .hit_port(),
		.res_done(lookup_done), .res_hit(lookup_hit), .res_port(lookup_dst_port)
	);

	// Source known test, combinational hit only
	way_match i_src_match (
		.clk(clk), .reset(reset), .res_en(1'b0),
		.key_mac(ctx_src_mac), .key_vlan(ctx_vlan),
		.way_valid(ln_rdata_valid), .way_mac(ln_rdata_mac),
		.way_vlan(ln_rdata_vlan), .way_port(ln_rdata_port),
		.hit(src_known), .hit_port(),
		.res_done(), .res_hit(), .res_port()
	);

	learn_queue i_learn_queue (
		.clk(clk), .reset(reset), .src_en(src_en), .src_row(src_row),
		.ctx_valid(ctx_valid), .ctx_src_mac(ctx_src_mac), .ctx_vlan(ctx_vlan),
		.ctx_src_port(ctx_src_port), .src_known(src_known),
		.ln_en(ln_en), .ln_row(ln_row), .ln_we(ln_we),
		.ln_wmac(ln_wmac), .ln_wvlan(ln_wvlan), .ln_wport(ln_wport)
	);

endmodule

`default_nettype wire

//--- logic/mac_table_pkg.sv
`default_nettype none

package mac_table_pkg;

	////////////////////////////////////////////////////////////
	// Table geometry

	// Rows in each way
	localparam int TABLE_ROWS = 64;
	// Associative ways per row
	localparam int ASSOC_WAYS = 4;
	// Addresses waiting to be written into the table
	localparam int PENDING_SIZE = 4;
	// Switch ports, 48 edge plus 2 uplink
	localparam int NUM_PORTS = 50;

	localparam int ROW_BITS = $clog2(TABLE_ROWS);
	localparam int WAY_BITS = $clog2(ASSOC_WAYS);
	localparam int PORT_BITS = $clog2(NUM_PORTS);
	localparam int PEND_BITS = $clog2(PENDING_SIZE);

	// I/G bit, set for broadcast and multicast
	localparam int GROUP_BIT = 40;

	////////////////////////////////////////////////////////////
	// Field types

	typedef logic [47:0] mac_t;
	typedef logic [11:0] vlan_t;
	typedef logic [PORT_BITS-1:0] port_t;
	typedef logic [ROW_BITS-1:0] row_t;
	typedef logic [WAY_BITS-1:0] way_t;

	// Row index from MAC and VLAN
	// Fold the MAC into 16 bits, mix in the VLAN, keep the low bits
	function automatic row_t table_hash(input mac_t mac, input vlan_t vlan);
		logic [15:0] folded;
		folded = mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ {4'h0, vlan};
		return folded[ROW_BITS-1:0];
	endfunction

endpackage

`default_nettype wire

//--- logic/request_decode.sv
`timescale 1ns/1ps
`default_nettype none

module request_decode import mac_table_pkg::*; (
	input wire clk,
	input wire reset,

	input wire req_valid,
	input wire port_t req_src_port,
	input wire vlan_t req_vlan,
	input wire mac_t req_src_mac,
	input wire mac_t req_dst_mac,

	output logic lk_en,
	output row_t lk_row,
	output logic src_en,
	output row_t src_row,

	output logic ctx_valid,
	output vlan_t ctx_vlan,
	output mac_t ctx_src_mac,
	output port_t ctx_src_port,
	output mac_t ctx_dst_mac
);

	// First delay stage
	logic s1_valid;
	vlan_t s1_vlan;
	mac_t s1_src_mac;
	port_t s1_src_port;
	mac_t s1_dst_mac;

	////////////////////////////////////////////////////////////
	// Table indexes

	// Both lookups run in the request cycle
	assign lk_en = req_valid;
	assign src_en = req_valid;
	// Source and destination share the request VLAN
	assign lk_row = table_hash(req_dst_mac, req_vlan);
	assign src_row = table_hash(req_src_mac, req_vlan);

	////////////////////////////////////////////////////////////
	// Context delay, two stages to match the memory read

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			ctx_valid <= 1'b0;
		end else begin
			s1_valid <= req_valid;
			ctx_valid <= s1_valid;
		end
	end

	// Payload fields
	always_ff @(posedge clk) begin
		s1_vlan <= req_vlan;
		s1_src_mac <= req_src_mac;
		s1_src_port <= req_src_port;
		s1_dst_mac <= req_dst_mac;

		ctx_vlan <= s1_vlan;
		ctx_src_mac <= s1_src_mac;
		ctx_src_port <= s1_src_port;
		ctx_dst_mac <= s1_dst_mac;
	end

endmodule

`default_nettype wire

//--- logic/table_memory.sv
`timescale 1ns/1ps
`default_nettype none

module table_memory import mac_table_pkg::*; (
	input wire clk,
	input wire reset,

	// Lookup port, read only
	input wire lk_en,
	input wire row_t lk_row,
	output logic [ASSOC_WAYS-1:0] lk_rdata_valid,
	output mac_t [ASSOC_WAYS-1:0] lk_rdata_mac,
	output vlan_t [ASSOC_WAYS-1:0] lk_rdata_vlan,
	output port_t [ASSOC_WAYS-1:0] lk_rdata_port,

	// Learn port, read or per-way write
	input wire ln_en,
	input wire row_t ln_row,
	input wire [ASSOC_WAYS-1:0] ln_we,
	input wire mac_t ln_wmac,
	input wire vlan_t ln_wvlan,
	input wire port_t ln_wport,
	output logic [ASSOC_WAYS-1:0] ln_rdata_valid,
	output mac_t [ASSOC_WAYS-1:0] ln_rdata_mac,
	output vlan_t [ASSOC_WAYS-1:0] ln_rdata_vlan,
	output port_t [ASSOC_WAYS-1:0] ln_rdata_port
);

	// Entry storage
	logic [TABLE_ROWS-1:0] valid_bits [ASSOC_WAYS];
	mac_t mac_mem [ASSOC_WAYS][TABLE_ROWS];
	vlan_t vlan_mem [ASSOC_WAYS][TABLE_ROWS];
	port_t port_mem [ASSOC_WAYS][TABLE_ROWS];

	// First output register of each port
	logic [ASSOC_WAYS-1:0] lk_s1_valid;
	mac_t [ASSOC_WAYS-1:0] lk_s1_mac;
	vlan_t [ASSOC_WAYS-1:0] lk_s1_vlan;
	port_t [ASSOC_WAYS-1:0] lk_s1_port;
	logic [ASSOC_WAYS-1:0] ln_s1_valid;
	mac_t [ASSOC_WAYS-1:0] ln_s1_mac;
	vlan_t [ASSOC_WAYS-1:0] ln_s1_vlan;
	port_t [ASSOC_WAYS-1:0] ln_s1_port;

	////////////////////////////////////////////////////////////
	// Writes, learn port only

	always_ff @(posedge clk) begin
		for (int w = 0; w < ASSOC_WAYS; w++) begin
			if (ln_en && ln_we[w]) begin
				mac_mem[w][ln_row] <= ln_wmac;
				vlan_mem[w][ln_row] <= ln_wvlan;
				port_mem[w][ln_row] <= ln_wport;
			end
		end
	end

	// Valid bits plus their read pipeline
	// A write only ever sets a bit
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < ASSOC_WAYS; w++)
				valid_bits[w] <= '0;
			lk_s1_valid <= '0;
			ln_s1_valid <= '0;
			lk_rdata_valid <= '0;
			ln_rdata_valid <= '0;
		end else begin
			for (int w = 0; w < ASSOC_WAYS; w++) begin
				if (ln_en && ln_we[w])
					valid_bits[w][ln_row] <= 1'b1;
				if (lk_en)
					lk_s1_valid[w] <= valid_bits[w][lk_row];
				if (ln_en)
					ln_s1_valid[w] <= valid_bits[w][ln_row];
			end
			lk_rdata_valid <= lk_s1_valid;
			ln_rdata_valid <= ln_s1_valid;
		end
	end

	////////////////////////////////////////////////////////////
	// Read data, two register stages per port

	// Read before write on the learn port
	always_ff @(posedge clk) begin
		for (int w = 0; w < ASSOC_WAYS; w++) begin
			if (lk_en) begin
				lk_s1_mac[w] <= mac_mem[w][lk_row];
				lk_s1_vlan[w] <= vlan_mem[w][lk_row];
				lk_s1_port[w] <= port_mem[w][lk_row];
			end
			if (ln_en) begin
				ln_s1_mac[w] <= mac_mem[w][ln_row];
				ln_s1_vlan[w] <= vlan_mem[w][ln_row];
				ln_s1_port[w] <= port_mem[w][ln_row];
			end
		end
		lk_rdata_mac <= lk_s1_mac;
		lk_rdata_vlan <= lk_s1_vlan;
		lk_rdata_port <= lk_s1_port;
		ln_rdata_mac <= ln_s1_mac;
		ln_rdata_vlan <= ln_s1_vlan;
		ln_rdata_port <= ln_s1_port;
	end

endmodule

`default_nettype wire

//--- logic/way_match.sv
`timescale 1ns/1ps
`default_nettype none

module way_match import mac_table_pkg::*; (
	input wire clk,
	input wire reset,
	// Loads the result register
	input wire res_en,

	input wire mac_t key_mac,
	input wire vlan_t key_vlan,
	input wire [ASSOC_WAYS-1:0] way_valid,
	input wire mac_t [ASSOC_WAYS-1:0] way_mac,
	input wire vlan_t [ASSOC_WAYS-1:0] way_vlan,
	input wire port_t [ASSOC_WAYS-1:0] way_port,

	output logic hit,
	output port_t hit_port,

	output logic res_done,
	output logic res_hit,
	output port_t res_port
);

	// Compare every way of the row
	// Later ways override earlier ones, so the top way wins on a double hit
	always_comb begin
		hit = 1'b0;
		hit_port = '0;
		for (int i = 0; i < ASSOC_WAYS; i++) begin
			if (way_valid[i] && (way_mac[i] == key_mac) && (way_vlan[i] == key_vlan)) begin
				hit = 1'b1;
				hit_port = way_port[i];
			end
		end
	end

	// Result register, hit and port held at zero between results
	always_ff @(posedge clk) begin
		if (reset) begin
			res_done <= 1'b0;
			res_hit <= 1'b0;
			res_port <= '0;
		end else begin
			res_done <= res_en;
			res_hit <= res_en && hit;
			res_port <= res_en ? hit_port : '0;
		end
	end

endmodule

`default_nettype wire

//--- mac_table.f
logic/mac_table_pkg.sv
logic/request_decode.sv
logic/table_memory.sv
logic/way_match.sv
logic/learn_queue.sv
logic/mac_table.sv
tb/tb_mac_table.sv

//--- tb/tb_mac_table.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_table import mac_table_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int PHASE1_REQS = 120;
	localparam int PHASE2_REQS = 160;
	// 12 cycles per request plus slack for reset and drain
	localparam int LIMIT_CYCLES = (PHASE1_REQS + PHASE2_REQS) * 12 + 200;
	localparam int POOL_SIZE = 12;

	logic clk;
	logic reset;
	logic req_valid;
	port_t req_src_port;
	vlan_t req_vlan;
	mac_t req_src_mac;
	mac_t req_dst_mac;
	logic lookup_done;
	logic lookup_hit;
	port_t lookup_dst_port;

	int cyc = 0;
	int unsigned lcg_state;

	// Reference table with the DUT geometry
	logic model_valid [TABLE_ROWS][ASSOC_WAYS];
	mac_t model_mac [TABLE_ROWS][ASSOC_WAYS];
	vlan_t model_vlan [TABLE_ROWS][ASSOC_WAYS];
	port_t model_port [TABLE_ROWS][ASSOC_WAYS];
	int model_ctr;
	// Pool entry and VLAN pairs learned at least once
	bit learned_ever [2*POOL_SIZE];

	// Coverage counters for phase one
	int hits_seen;
	int replacements;
	int evicted_misses;

	// Expected results, oldest first
	int exp_due [$];
	logic exp_hit [$];
	port_t exp_port [$];
	bit exp_exact [$];
	bit exp_group [$];

	mac_table i_mac_table (
		.clk(clk), .reset(reset), .req_valid(req_valid),
		.req_src_port(req_src_port), .req_vlan(req_vlan),
		.req_src_mac(req_src_mac), .req_dst_mac(req_dst_mac),
		.lookup_done(lookup_done), .lookup_hit(lookup_hit),
		.lookup_dst_port(lookup_dst_port)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	////////////////////////////////////////////////////////////
	// Helpers

	// LCG step that returns the upper bits
	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	function automatic mac_t pool_address(input int idx);
		// Six unicast addresses fold onto one row per VLAN
		if (idx < 6)
			return {16'h0200, 8'(idx), 8'h00, 16'h0005};
		// Four unicast addresses on separate rows within a VLAN
		if (idx < 10)
			return {16'h0200, 16'h0000, 16'(16 + 3 * idx)};
		// Multicast addresses with the I/G bit set
		return {16'h0100, 8'(idx), 8'h00, 16'h0005};
	endfunction

	// Row index from a 16-bit fold of MAC and VLAN
	function automatic row_t row_of(input mac_t mac, input vlan_t vlan);
		logic [15:0] folded;
		folded = mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ {4'h0, vlan};
		return folded[ROW_BITS-1:0];
	endfunction

	// Highest matching way wins
	function automatic logic model_find(input mac_t mac, input vlan_t vlan, output port_t port);
		row_t row;
		logic found;
		row = row_of(mac, vlan);
		found = 1'b0;
		port = '0;
		for (int w = 0; w < ASSOC_WAYS; w++) begin
			if (model_valid[row][w] && model_mac[row][w] == mac && model_vlan[row][w] == vlan) begin
				found = 1'b1;
				port = model_port[row][w];
			end
		end
		return found;
	endfunction

	// Unknown unicast source goes to the way under the counter
	task automatic model_learn(input int id, input mac_t mac, input vlan_t vlan, input port_t port);
		row_t row;
		port_t known_port;
		if (mac[GROUP_BIT] || model_find(mac, vlan, known_port))
			return;
		row = row_of(mac, vlan);
		if (model_valid[row][model_ctr])
			replacements++;
		model_valid[row][model_ctr] = 1'b1;
		model_mac[row][model_ctr] = mac;
		model_vlan[row][model_ctr] = vlan;
		model_port[row][model_ctr] = port;
		learned_ever[id] = 1'b1;
		model_ctr = (model_ctr + 1) % ASSOC_WAYS;
	endtask

	task automatic stop_run();
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		$display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
		stop_run();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR time=%0t %s", $time, what);
		stop_run();
	endtask

	// Inputs move 1 ns after the edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	// One random request
	// The model is exact only when learns have settled
	task automatic send_request(input bit exact);
		int src_id;
		int dst_id;
		int vlan_sel;
		port_t dst_port;
		logic hit;
		src_id = next_random() % POOL_SIZE;
		dst_id = next_random() % POOL_SIZE;
		vlan_sel = next_random() % 2;
		req_valid = 1'b1;
		req_vlan = vlan_t'(vlan_sel + 1);
		req_src_mac = pool_address(src_id);
		req_dst_mac = pool_address(dst_id);
		req_src_port = port_t'(next_random() % NUM_PORTS);
		// Lookup sees the table before this request's own learn
		hit = model_find(req_dst_mac, req_vlan, dst_port);
		if (exact && hit)
			hits_seen++;
		if (exact && !hit && learned_ever[vlan_sel * POOL_SIZE + dst_id])
			evicted_misses++;
		exp_due.push_back(cyc + 3);
		exp_hit.push_back(hit);
		exp_port.push_back(dst_port);
		exp_exact.push_back(exact);
		exp_group.push_back(req_dst_mac[GROUP_BIT]);
		if (exact)
			model_learn(vlan_sel * POOL_SIZE + src_id, req_src_mac, req_vlan, req_src_port);
		step();
	endtask

	////////////////////////////////////////////////////////////
	// Output checks at the falling edge

	task automatic check_outputs();
		if (exp_due.size() > 0 && exp_due[0] == cyc) begin
			assert (lookup_done === 1'b1)
				else report_mismatch("lookup_done", 64'(lookup_done), 64'd1);
			if (exp_exact[0]) begin
				assert (lookup_hit === exp_hit[0])
					else report_mismatch("lookup_hit", 64'(lookup_hit), 64'(exp_hit[0]));
				assert (lookup_dst_port === exp_port[0])
					else report_mismatch("lookup_dst_port", 64'(lookup_dst_port),
						64'(exp_port[0]));
			end
			// Group addresses never get into the table
			if (exp_group[0])
				assert (lookup_hit === 1'b0)
					else report_mismatch("lookup_hit", 64'(lookup_hit), 64'd0);
			void'(exp_due.pop_front());
			void'(exp_hit.pop_front());
			void'(exp_port.pop_front());
			void'(exp_exact.pop_front());
			void'(exp_group.pop_front());
		end else begin
			assert (lookup_done === 1'b0)
				else report_mismatch("lookup_done", 64'(lookup_done), 64'd0);
			assert (lookup_hit === 1'b0)
				else report_mismatch("lookup_hit", 64'(lookup_hit), 64'd0);
			assert (lookup_dst_port === '0)
				else report_mismatch("lookup_dst_port", 64'(lookup_dst_port), 64'd0);
		end
	endtask

	always @(negedge clk) begin
		if (!reset)
			check_outputs();
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		report_problem("timeout, the run did not finish in time");
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int sent;
		int burst;
		int gap;
		reset = 1'b1;
		req_valid = 1'b0;
		req_src_port = '0;
		req_vlan = '0;
		req_src_mac = '0;
		req_dst_mac = '0;
		lcg_state = 7;
		hits_seen = 0;
		replacements = 0;
		evicted_misses = 0;
		model_ctr = 0;
		for (int r = 0; r < TABLE_ROWS; r++)
			for (int w = 0; w < ASSOC_WAYS; w++)
				model_valid[r][w] = 1'b0;
		for (int i = 0; i < 2 * POOL_SIZE; i++)
			learned_ever[i] = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// Quiet bus where lookup_done must stay low
		repeat (10) step();

		// Phase one spaces requests 10 cycles apart so each learn settles
		for (int n = 0; n < PHASE1_REQS; n++) begin
			send_request(1'b1);
			req_valid = 1'b0;
			repeat (9) step();
		end
		assert (hits_seen > 0) else report_problem("phase one saw no destination hit");
		assert (replacements > 0) else report_problem("phase one never replaced a table entry");
		assert (evicted_misses > 0) else report_problem("no replaced address was looked up");

		// Phase two sends bursts with short gaps
		// A zero gap runs two bursts together
		sent = 0;
		while (sent < PHASE2_REQS) begin
			burst = 1 + next_random() % 8;
			for (int k = 0; k < burst && sent < PHASE2_REQS; k++) begin
				send_request(1'b0);
				sent++;
			end
			req_valid = 1'b0;
			gap = next_random() % 3;
			repeat (gap) step();
		end

		// Drain the pipeline
		repeat (8) step();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
